// File: dtimLsu.f
source/rvMemPkg.sv
source/dtimPkg.sv
source/lsuRequestDecode.sv
source/dtimBank.sv
source/loadAlign.sv
source/dtimLsu.sv
test/clockGen.sv
test/dtimLsuTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the DTIM LSU testbench with Verilator and runs it.
# Exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
  --top-module dtimLsuTb \
  -f dtimLsu.f \
  -o dtimLsuSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/dtimLsuSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

// File: source/dtimBank.sv
////////////////////////////////////////
// DTIM byte lane
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dtimBank import rvMemPkg::*, dtimPkg::*; (
  input  logic    clk,
  input  bankCmdT cmd,
  output byteT    readByte   // Valid the cycle after rdEn
);

  byteT mem [DTIM_DEPTH];    // One byte per word row

  ////////////////////////////////////////
  // Write port

  // Written at the end of the request cycle
  always_ff @(posedge clk) begin
    if (cmd.wrEn) begin
      mem[cmd.wordAdr] <= cmd.wrByte;
    end
  end

  ////////////////////////////////////////
  // Read port

  // Synchronous read, holds the last byte while idle
  always_ff @(posedge clk) begin
    if (cmd.rdEn) begin
      readByte <= mem[cmd.wordAdr];
    end
  end

endmodule

`default_nettype wire

// File: source/dtimLsu.sv
////////////////////////////////////////
// DTIM load/store unit
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dtimLsu import rvMemPkg::*, dtimPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  memReqT   req,                   // Level request, one per cycle
  output dataWordT readData,              // Load result, cycle after the request
  output logic     readValid,
  output logic     loadMisalignedFault,   // One-cycle pulse after a bad load
  output logic     storeMisalignedFault   // One-cycle pulse after a bad store
);

  bankCmdT bankCmd   [BYTES_PER_WORD];    // Decoder to banks
  byteT    laneBytes [BYTES_PER_WORD];    // Banks to aligner
  loadCtlT loadCtl;                       // Decoder to aligner, one cycle late

  ////////////////////////////////////////
  // Request decode

  lsuRequestDecode decode (
    .clk,
    .arstN,
    .req,
    .bankCmd,
    .loadCtl,
    .loadMisalignedFault,
    .storeMisalignedFault
  );

  ////////////////////////////////////////
  // Byte lane banks

  for (genvar lane = 0; lane < BYTES_PER_WORD; lane++) begin : gBank
    dtimBank bank (
      .clk,
      .cmd      (bankCmd[lane]),
      .readByte (laneBytes[lane])
    );
  end

  ////////////////////////////////////////
  // Load data path

  loadAlign align (
    .laneBytes,
    .loadCtl,
    .readData,
    .readValid
  );

endmodule

`default_nettype wire

// File: source/dtimPkg.sv
////////////////////////////////////////
// DTIM geometry and LSU structs
////////////////////////////////////////

`default_nettype none

package dtimPkg;

  import rvMemPkg::*;

  ////////////////////////////////////////
  // Geometry

  localparam int DTIM_DEPTH    = 256;                       // Words per bank
  localparam int WORD_ADR_BITS = $clog2(DTIM_DEPTH);        // 8
  localparam int OFFSET_BITS   = $clog2(BYTES_PER_WORD);    // Byte within a word
  localparam int BYTE_ADR_BITS = WORD_ADR_BITS + OFFSET_BITS;

  typedef logic [BYTE_ADR_BITS-1:0] byteAdrT;     // Byte address into the DTIM
  typedef logic [WORD_ADR_BITS-1:0] wordAdrT;     // Row in every bank
  typedef logic [OFFSET_BITS-1:0]   byteOffsetT;  // Byte position inside a word

  ////////////////////////////////////////
  // Structs between blocks

  typedef struct packed {
    memRwT    rw;         // MEM_READ, MEM_WRITE or MEM_IDLE
    funct3T   funct3;     // Size and signedness
    byteAdrT  adr;
    dataWordT writeData;  // Value in the low bytes, as from the register file
    logic     bigEndian;  // Per-request byte order
  } memReqT;

  typedef struct packed {
    logic    rdEn;
    logic    wrEn;
    wordAdrT wordAdr;
    byteT    wrByte;
  } bankCmdT;

  typedef struct packed {
    logic       valid;      // A load was issued last cycle
    funct3T     funct3;
    byteOffsetT offset;
    logic       bigEndian;
  } loadCtlT;

  // Distance from a value's first byte to its last one, by size
  function automatic byteOffsetT sizeLastByte(funct3T funct3);
    case (funct3[1:0])
      SIZE_BYTE: return byteOffsetT'(0);
      SIZE_HALF: return byteOffsetT'(1);
      default:   return byteOffsetT'(BYTES_PER_WORD - 1);  // Word and unused code 3
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/loadAlign.sv
////////////////////////////////////////
// Load data aligner
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module loadAlign import rvMemPkg::*, dtimPkg::*; (
  input  byteT     laneBytes [BYTES_PER_WORD],  // Bank outputs, lane order
  input  loadCtlT  loadCtl,                     // Registered facts of last cycle's load
  output dataWordT readData,
  output logic     readValid
);

  byteT       memBytes [BYTES_PER_WORD];  // Word bytes in address order
  byteT       valBytes [BYTES_PER_WORD];  // Value bytes, LS byte first
  byteOffsetT lastByte;
  logic       isUnsigned;
  logic       signBit;

  assign lastByte   = sizeLastByte(loadCtl.funct3);
  assign isUnsigned = loadCtl.funct3[F3_UNSIGNED];
  assign readValid  = loadCtl.valid;

  ////////////////////////////////////////
  // Lane to memory order

  for (genvar pos = 0; pos < BYTES_PER_WORD; pos++) begin : gMemOrder
    // Big-endian mode mirrors the lanes
    assign memBytes[pos] = loadCtl.bigEndian ? laneBytes[BYTES_PER_WORD - 1 - pos]
                                             : laneBytes[pos];
  end

  ////////////////////////////////////////
  // Byte pick at the offset

  for (genvar i = 0; i < BYTES_PER_WORD; i++) begin : gPick
    byteOffsetT srcPos;  // Address position of value byte i

    // Big-endian keeps the LS byte at the highest address of the value
    assign srcPos = loadCtl.bigEndian ? byteOffsetT'(loadCtl.offset + lastByte - i)
                                      : byteOffsetT'(loadCtl.offset + i);
    assign valBytes[i] = memBytes[srcPos];  // Bytes past the size are dropped below
  end

  ////////////////////////////////////////
  // Sign or zero extension

  always_comb begin
    case (loadCtl.funct3[1:0])
      SIZE_BYTE: begin
        signBit  = ~isUnsigned & valBytes[0][7];
        readData = {{(XLEN-8){signBit}}, valBytes[0]};
      end
      SIZE_HALF: begin
        signBit  = ~isUnsigned & valBytes[1][7];
        readData = {{(XLEN-16){signBit}}, valBytes[1], valBytes[0]};
      end
      default: begin                   // Word, nothing to extend
        signBit  = 1'b0;
        readData = {valBytes[3], valBytes[2], valBytes[1], valBytes[0]};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/lsuRequestDecode.sv
////////////////////////////////////////
// LSU request decoder
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsuRequestDecode import rvMemPkg::*, dtimPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  memReqT  req,
  output bankCmdT bankCmd [BYTES_PER_WORD],  // One command per byte lane
  output loadCtlT loadCtl,                   // Registered, used by the aligner next cycle
  output logic    loadMisalignedFault,
  output logic    storeMisalignedFault
);

  logic       isRead;
  logic       isWrite;
  logic       misaligned;
  byteOffsetT offset;     // Byte position of the first byte
  wordAdrT    wordAdr;
  byteOffsetT lastByte;   // Size minus one, in bytes
  byteMaskT   byteMask;   // Bytes covered, in memory order

  ////////////////////////////////////////
  // Address split and alignment

  assign isRead   = (req.rw == MEM_READ);
  assign isWrite  = (req.rw == MEM_WRITE);
  assign offset   = req.adr[OFFSET_BITS-1:0];
  assign wordAdr  = req.adr[BYTE_ADR_BITS-1:OFFSET_BITS];
  assign lastByte = sizeLastByte(req.funct3);

  // Halfword needs bit 0 clear, word needs both bits clear
  assign misaligned = |(offset & lastByte);

  // Position pos is covered when it lies within offset..offset+lastByte
  always_comb begin
    for (int pos = 0; pos < BYTES_PER_WORD; pos++) begin
      byteMask[pos] = (byteOffsetT'(pos - offset) <= lastByte);
    end
  end

  ////////////////////////////////////////
  // Lane commands

  for (genvar lane = 0; lane < BYTES_PER_WORD; lane++) begin : gLane
    byteOffsetT memPos;    // Word position this lane holds
    byteOffsetT valueIdx;  // Byte of writeData that lands here

    // Lane k holds position k, or position 3-k in big-endian mode
    assign memPos = req.bigEndian ? byteOffsetT'(BYTES_PER_WORD - 1 - lane)
                                  : byteOffsetT'(lane);

    // LS byte goes to the lowest address, or the highest one in big-endian mode
    assign valueIdx = req.bigEndian ? byteOffsetT'(offset + lastByte - memPos)
                                    : byteOffsetT'(memPos - offset);

    assign bankCmd[lane] = '{
      rdEn:    isRead & ~misaligned,                     // All lanes read, aligner picks
      wrEn:    isWrite & ~misaligned & byteMask[memPos],
      wordAdr: wordAdr,
      wrByte:  req.writeData[8*valueIdx +: 8]
    };
  end

  ////////////////////////////////////////
  // Next-cycle load control and faults

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      loadCtl              <= '0;
      loadMisalignedFault  <= 1'b0;
      storeMisalignedFault <= 1'b0;
    end else begin
      loadCtl.valid        <= isRead & ~misaligned;  // Suppressed load returns nothing
      loadCtl.funct3       <= req.funct3;
      loadCtl.offset       <= offset;
      loadCtl.bigEndian    <= req.bigEndian;
      loadMisalignedFault  <= isRead & misaligned;   // High for one cycle only
      storeMisalignedFault <= isWrite & misaligned;
    end
  end

endmodule

`default_nettype wire

// File: source/rvMemPkg.sv
////////////////////////////////////////
// RISC-V memory operation encodings
////////////////////////////////////////

`default_nettype none

package rvMemPkg;

  ////////////////////////////////////////
  // Data path widths

  localparam int XLEN           = 32;          // Integer register width
  localparam int BYTES_PER_WORD = XLEN / 8;    // Byte lanes per data word

  typedef logic [XLEN-1:0]           dataWordT;  // Full data word
  typedef logic [7:0]                byteT;      // One byte lane
  typedef logic [BYTES_PER_WORD-1:0] byteMaskT;  // One enable per byte lane

  ////////////////////////////////////////
  // Read/write code

  typedef logic [1:0] memRwT;

  localparam memRwT MEM_IDLE  = 2'b00;  // No access this cycle
  localparam memRwT MEM_WRITE = 2'b01;  // Store
  localparam memRwT MEM_READ  = 2'b10;  // Load

  ////////////////////////////////////////
  // funct3 size and signedness

  typedef logic [2:0] funct3T;
  typedef logic [1:0] memSizeT;         // Low two bits of funct3

  localparam memSizeT SIZE_BYTE = 2'd0; // lb, lbu, sb
  localparam memSizeT SIZE_HALF = 2'd1; // lh, lhu, sh
  localparam memSizeT SIZE_WORD = 2'd2; // lw, sw; code 3 is treated the same

  localparam int F3_UNSIGNED = 2;       // Set for lbu and lhu

endpackage

`default_nettype wire

// File: test/clockGen.sv
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic arstN
);

  localparam int RESET_CYCLES = 4;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    arstN = 1'b0;                        // Held low from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    arstN <= 1'b1;                       // Release right after the 4th edge
  end

endmodule

`default_nettype wire

// File: test/dtimLsuTb.sv
////////////////////////////////////////
// DTIM LSU testbench
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dtimLsuTb import rvMemPkg::*, dtimPkg::*; ();

  localparam logic [31:0] LFSR_SEED = 32'ha29c;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
  localparam int CYCLE_LIMIT = 4000;                 // Tests need about 1450 cycles
  localparam int MODEL_BYTES = DTIM_DEPTH * BYTES_PER_WORD;

  localparam funct3T F3_LB  = 3'b000;  // Same code as sb
  localparam funct3T F3_LH  = 3'b001;  // Same code as sh
  localparam funct3T F3_LW  = 3'b010;  // Same code as sw
  localparam funct3T F3_LBU = 3'b100;
  localparam funct3T F3_LHU = 3'b101;

  typedef struct packed {
    logic     valid;
    dataWordT data;
    dataWordT mask;        // Bits that come from written bytes
    logic     loadFault;
    logic     storeFault;
  } expectT;

  logic     clk;
  logic     arstN;
  memReqT   req;
  dataWordT readData;
  logic     readValid;
  logic     loadMisalignedFault;
  logic     storeMisalignedFault;

  expectT      expNext;                 // For the request driven this cycle
  expectT      expCur;                  // For the DUT outputs of this cycle
  byteT        memModel [MODEL_BYTES];  // Word index times four plus lane
  logic        written  [MODEL_BYTES];
  logic [31:0] lfsrState;
  int          mismatchCount = 0;
  int          otherCount    = 0;
  int          cycleCount    = 0;

  clockGen clocks (
    .clk   (clk),
    .arstN (arstN)
  );

  dtimLsu uut (
    .clk                  (clk),
    .arstN                (arstN),
    .req                  (req),
    .readData             (readData),
    .readValid            (readValid),
    .loadMisalignedFault  (loadMisalignedFault),
    .storeMisalignedFault (storeMisalignedFault)
  );

  ////////////////////////////////////////
  // Random bits

  // Galois form, one step per bit
  function automatic logic lfsrStep();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = {1'b0, lfsrState[31:1]} ^ (outBit ? LFSR_TAPS : 32'h0);
    return outBit;
  endfunction

  function automatic logic [31:0] randomBits(int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      value[i] = lfsrStep();
    end
    return value;
  endfunction

  ////////////////////////////////////////
  // Reference byte memory

  function automatic int sizeBytes(funct3T f3);
    case (f3[1:0])
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return BYTES_PER_WORD;  // Word and code 3
    endcase
  endfunction

  function automatic logic isMisaligned(byteAdrT adr, funct3T f3);
    return (int'(adr[OFFSET_BITS-1:0]) % sizeBytes(f3)) != 0;
  endfunction

  // Word position pos sits in lane pos, mirrored in big-endian mode
  function automatic int modelIndex(byteAdrT adr, int pos, logic be);
    int lane;
    lane = be ? BYTES_PER_WORD - 1 - pos : pos;
    return int'(adr[BYTE_ADR_BITS-1:OFFSET_BITS]) * BYTES_PER_WORD + lane;
  endfunction

  function automatic void storeModel(byteAdrT adr, funct3T f3, dataWordT data, logic be);
    int n;
    int idx;
    n = sizeBytes(f3);
    for (int i = 0; i < n; i++) begin
      idx = modelIndex(adr, int'(adr[OFFSET_BITS-1:0]) + i, be);
      memModel[idx] = be ? data[8*(n-1-i) +: 8] : data[8*i +: 8];  // LS byte at the far end in BE
      written[idx]  = 1'b1;
    end
  endfunction

  function automatic expectT loadExpect(byteAdrT adr, funct3T f3, logic be);
    expectT e;
    int     n;
    int     pos;
    int     idx;
    logic   ext;
    e       = '0;
    e.valid = 1'b1;
    n       = sizeBytes(f3);
    for (int i = 0; i < n; i++) begin
      pos = be ? int'(adr[OFFSET_BITS-1:0]) + n - 1 - i : int'(adr[OFFSET_BITS-1:0]) + i;
      idx = modelIndex(adr, pos, be);
      if (written[idx]) begin
        e.data[8*i +: 8] = memModel[idx];
        e.mask[8*i +: 8] = 8'hff;
      end
    end
    // Upper bits are known if zero-filled or if the sign byte was written
    if (n < BYTES_PER_WORD && (f3[F3_UNSIGNED] || e.mask[8*n-1])) begin
      ext = ~f3[F3_UNSIGNED] & e.data[8*n-1];
      for (int b = 8*n; b < XLEN; b++) begin
        e.data[b] = ext;
        e.mask[b] = 1'b1;
      end
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // Request driver

  task automatic issueRequest(memRwT op, funct3T f3, byteAdrT adr, dataWordT data, logic be);
    expectT e;
    e = '0;
    if (op != MEM_IDLE && isMisaligned(adr, f3)) begin
      e.loadFault  = (op == MEM_READ);   // Suppressed, model untouched
      e.storeFault = (op == MEM_WRITE);
    end else if (op == MEM_READ) begin
      e = loadExpect(adr, f3, be);
    end else if (op == MEM_WRITE) begin
      storeModel(adr, f3, data, be);
    end
    @(posedge clk);
    req     <= '{rw: op, funct3: f3, adr: adr, writeData: data, bigEndian: be};
    expNext <= e;
  endtask

  function automatic byteAdrT randomWordAdr();
    return byteAdrT'({wordAdrT'(randomBits(WORD_ADR_BITS)), byteOffsetT'(0)});
  endfunction

  ////////////////////////////////////////
  // Test sequences

  task automatic wordRoundTrip(int count, int burst);
    byteAdrT adr;
    byteAdrT burstAdr [$];
    for (int i = 0; i < count; i++) begin
      adr = randomWordAdr();
      issueRequest(MEM_WRITE, F3_LW, adr, randomBits(XLEN), 1'b0);
      issueRequest(MEM_READ, F3_LW, adr, '0, 1'b0);
    end
    for (int i = 0; i < burst; i++) begin      // Stores back to back
      burstAdr.push_back(randomWordAdr());
      issueRequest(MEM_WRITE, F3_LW, burstAdr[i], randomBits(XLEN), 1'b0);
    end
    for (int i = 0; i < burst; i++) begin      // Loads back to back, two in flight
      issueRequest(MEM_READ, F3_LW, burstAdr[i], '0, 1'b0);
    end
  endtask

  task automatic subWordStores(int count);
    byteAdrT     adr;
    logic [31:0] pick;
    byteOffsetT  off;
    for (int i = 0; i < count; i++) begin
      adr = randomWordAdr();
      issueRequest(MEM_WRITE, F3_LW, adr, randomBits(XLEN), 1'b0);
      pick = randomBits(3);
      off  = pick[0] ? byteOffsetT'({pick[1], 1'b0}) : byteOffsetT'(pick[2:1]);
      issueRequest(MEM_WRITE, pick[0] ? F3_LH : F3_LB, adr | byteAdrT'(off),
                   randomBits(XLEN), 1'b0);
      issueRequest(MEM_READ, F3_LW, adr, '0, 1'b0);
    end
  endtask

  task automatic extensionLoads(int count, logic be);
    byteAdrT adr;
    for (int i = 0; i < count; i++) begin
      adr = randomWordAdr();
      issueRequest(MEM_WRITE, F3_LW, adr, randomBits(XLEN), be);
      if (be) begin
        issueRequest(MEM_READ, F3_LW, adr, '0, be);  // Round trip
      end
      for (int off = 0; off < BYTES_PER_WORD; off++) begin
        issueRequest(MEM_READ, F3_LB, adr | byteAdrT'(off), '0, be);
        if (!be) begin
          issueRequest(MEM_READ, F3_LBU, adr | byteAdrT'(off), '0, be);
        end
      end
      for (int off = 0; off < BYTES_PER_WORD; off += 2) begin
        issueRequest(MEM_READ, F3_LH, adr | byteAdrT'(off), '0, be);
        if (!be) begin
          issueRequest(MEM_READ, F3_LHU, adr | byteAdrT'(off), '0, be);
        end
      end
    end
  endtask

  task automatic misalignedAccess(int count);
    byteAdrT     adr;
    logic [31:0] pick;
    byteOffsetT  off;
    for (int i = 0; i < count; i++) begin
      adr = randomWordAdr();
      issueRequest(MEM_WRITE, F3_LW, adr, randomBits(XLEN), 1'b0);
      pick = randomBits(4);
      off  = byteOffsetT'(pick[3:2]);
      if (pick[1]) begin
        off = (off == 0) ? byteOffsetT'(2) : off;          // Word, any nonzero offset
      end else begin
        off = byteOffsetT'({pick[2], 1'b1});               // Halfword, odd offset
      end
      issueRequest(pick[0] ? MEM_WRITE : MEM_READ, pick[1] ? F3_LW : F3_LH,
                   adr | byteAdrT'(off), randomBits(XLEN), 1'b0);
      issueRequest(MEM_READ, F3_LW, adr, '0, 1'b0);        // Word must be unchanged
    end
  endtask

  ////////////////////////////////////////
  // Checks

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      expCur <= '0;
    end else begin
      expCur <= expNext;   // Outputs lag the request by one cycle
    end
  end

  assert property (@(posedge clk) arstN || !(readValid || loadMisalignedFault
                                            || storeMisalignedFault))
    else begin
      otherCount++;
      $display("reset at %0t: an output is high while reset is asserted", $time);
    end

  assert property (@(posedge clk) readValid == expCur.valid)
    else begin
      mismatchCount++;
      $display("mismatch at %0t: readValid got %b expected %b", $time,
               $sampled(readValid), $sampled(expCur.valid));
    end

  assert property (@(posedge clk)
                   !expCur.valid || ((readData & expCur.mask) == (expCur.data & expCur.mask)))
    else begin
      mismatchCount++;
      $display("mismatch at %0t: readData got %h expected %h (mask %h)", $time,
               $sampled(readData), $sampled(expCur.data), $sampled(expCur.mask));
    end

  assert property (@(posedge clk) loadMisalignedFault == expCur.loadFault)
    else begin
      mismatchCount++;
      $display("mismatch at %0t: loadMisalignedFault got %b expected %b", $time,
               $sampled(loadMisalignedFault), $sampled(expCur.loadFault));
    end

  assert property (@(posedge clk) storeMisalignedFault == expCur.storeFault)
    else begin
      mismatchCount++;
      $display("mismatch at %0t: storeMisalignedFault got %b expected %b", $time,
               $sampled(storeMisalignedFault), $sampled(expCur.storeFault));
    end

  // Hang guard
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles, %0d errors so far",
               CYCLE_LIMIT, mismatchCount + otherCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Main sequence

  initial begin
    lfsrState = LFSR_SEED;
    for (int i = 0; i < MODEL_BYTES; i++) begin
      written[i]  = 1'b0;
      memModel[i] = '0;
    end
    // Live requests while reset is held, none of them may reach the outputs
    req     <= '{rw: MEM_READ, funct3: F3_LW, adr: '0, writeData: '0, bigEndian: 1'b0};
    expNext <= '0;
    @(posedge clk);
    req <= '{rw: MEM_READ, funct3: F3_LW, adr: byteAdrT'(2), writeData: '0,
             bigEndian: 1'b0};                 // Misaligned load
    @(posedge clk);
    req <= '{rw: MEM_WRITE, funct3: F3_LH, adr: byteAdrT'(1), writeData: '1,
             bigEndian: 1'b0};                 // Misaligned store, writes nothing
    wait (arstN === 1'b1);
    req <= '0;                          // Idle from the release edge on
    repeat (2) @(posedge clk);          // Idle cycles right after reset

    wordRoundTrip(100, 32);
    subWordStores(100);
    extensionLoads(32, 1'b0);           // Little-endian, signed and unsigned
    extensionLoads(32, 1'b1);           // Big-endian byte order
    misalignedAccess(60);

    issueRequest(MEM_IDLE, F3_LW, '0, '0, 1'b0);
    repeat (3) @(posedge clk);          // Let the last outputs be checked

    $display("Checks done: %0d value mismatches, %0d other errors",
             mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
